/* Bender.yml */
package:
  name: cpu_pipeline

export_include_dirs:
  - include

sources:
  - files:
      - verilog/isa_pkg.sv
      - verilog/pipe_pkg.sv
      - verilog/reg_file.sv
      - verilog/fetch_stage.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/cpu_top.sv
  - target: test
    files:
      - testbench/cpu_assertions.sv
      - testbench/cpu_tb.sv

/* flist.f */
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_top.sv
testbench/cpu_assertions.sv
testbench/cpu_tb.sv

/* include/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// code memory depth in 32-bit words
`define CODE_WORDS 16

// data memory depth in 32-bit words
`define DATA_WORDS 8

// general registers r0 to r14, r15 reads back the pc
`define NUM_REGS 15

// pc advance per instruction, in bytes
`define PC_STEP 4

// r15 reads and branch bases run two instructions ahead
`define PC_READ_OFFSET 8

`endif

/* testbench/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions import pipe_pkg::*; (
  input logic    clk,
  input logic    nreset,
  input retire_t retire,
  input store_t  store,
  input logic    branch_taken
);

  // read by the testbench at the end of the run
  int unsigned fails = 0;

  ////////////////////////////////////////
  // port checks

  // nothing leaves the core in the cycle after a reset edge
  idle_after_reset: assert property (@(posedge clk) !nreset |=> !retire.valid && !store.valid)
    else begin
      $error("retire or store active in the cycle after reset");
      fails++;
    end

  // r15 is never a write-back target
  no_pc_retire: assert property (@(posedge clk) disable iff (!nreset)
    retire.valid |-> retire.rd != 4'd15)
    else begin
      $error("retire wrote r15");
      fails++;
    end

  // the branch slot reaches write-back two cycles on and the flushed slots follow
  flushed_slots_quiet: assert property (@(posedge clk) disable iff (!nreset)
    branch_taken |-> ##2 (!retire.valid) [*3])
    else begin
      $error("retire from a slot behind a taken branch");
      fails++;
    end

endmodule

bind cpu_top cpu_assertions asrt0 (
  .clk, .nreset, .retire, .store, .branch_taken
);

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb import isa_pkg::*; import pipe_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int WATCHDOG_CYCLES = 40 * `CODE_WORDS;

  logic     clk;
  logic     nreset;
  prog_wr_t prog;
  retire_t  retire;
  store_t   store;

  word_t    code [`CODE_WORDS];
  retire_t  exp_ret[$];
  store_t   exp_st[$];
  int       errors = 0;

  cpu_top dut0 (
    .clk, .nreset, .prog, .retire, .store
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // instruction encoding

  function automatic word_t dp_word(input cond_e c, input opcode_e op, input logic imm,
                                    input logic s, input int rd, input int rn,
                                    input logic [11:0] op2);
    return {c, 2'b00, imm, op, s, 4'(rn), 4'(rd), op2};
  endfunction

  // pre-indexed, offset added, no writeback
  function automatic word_t ldst_word(input cond_e c, input logic l, input int rd,
                                      input int rn, input logic [11:0] off);
    return {c, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, l, 4'(rn), 4'(rd), off};
  endfunction

  function automatic word_t branch_word(input cond_e c, input logic [23:0] imm24);
    return {c, 3'b101, 1'b0, imm24};
  endfunction

  task automatic build_program();
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [11:0] off;
    a   = 8'($urandom);
    // nonzero so the compare below is strictly greater
    b   = 8'($urandom % 255 + 1);
    c   = 8'($urandom);
    off = 12'($urandom % 64);
    code[0]  = dp_word(COND_AL, OP_MOV, 1'b1, 1'b0, 0, 0, {4'h0, a});
    code[1]  = dp_word(COND_AL, OP_ADD, 1'b1, 1'b0, 1, 0, {4'h0, b});
    code[2]  = dp_word(COND_AL, OP_ADD, 1'b0, 1'b0, 2, 1, 12'd0);
    code[3]  = dp_word(COND_AL, OP_RSB, 1'b1, 1'b1, 3, 2, {4'h0, c});
    code[4]  = dp_word(COND_AL, OP_EOR, 1'b0, 1'b0, 4, 3, 12'd1);
    code[5]  = ldst_word(COND_AL, 1'b0, 4, 0, off);
    code[6]  = ldst_word(COND_AL, 1'b1, 5, 0, off);
    code[7]  = dp_word(COND_AL, OP_ADD, 1'b0, 1'b0, 6, 5, 12'd2);
    code[8]  = dp_word(COND_AL, OP_CMP, 1'b0, 1'b1, 0, 1, 12'd0);
    code[9]  = branch_word(COND_EQ, 24'd0);
    code[10] = branch_word(COND_GT, 24'd0);
    // skipped by the taken branch
    code[11] = dp_word(COND_AL, OP_MOV, 1'b1, 1'b0, 7, 0, 12'd1);
    code[12] = dp_word(COND_AL, OP_TST, 1'b1, 1'b1, 0, 0, 12'd0);
    code[13] = dp_word(COND_NE, OP_MOV, 1'b1, 1'b0, 8, 0, 12'd2);
    code[14] = branch_word(COND_LT, 24'(-16));
    code[15] = branch_word(COND_AL, 24'(-2));
  endtask

  ////////////////////////////////////////
  // instruction-set model

  function automatic logic cond_holds(input logic [3:0] cond, input logic n, input logic z,
                                      input logic c, input logic v);
    case (cond_e'(cond))
      COND_EQ: return z;
      COND_NE: return !z;
      COND_CS: return c;
      COND_CC: return !c;
      COND_MI: return n;
      COND_PL: return !n;
      COND_VS: return v;
      COND_VC: return !v;
      COND_HI: return c && !z;
      COND_LS: return !c || z;
      COND_GE: return n == v;
      COND_LT: return n != v;
      COND_GT: return !z && (n == v);
      COND_LE: return z || (n != v);
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic model_program();
    word_t      r [16];
    word_t      dmem [`DATA_WORDS];
    word_t      pc;
    word_t      inst;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      sum;
    logic       n;
    logic       z;
    logic       c;
    logic       v;
    logic       cy;
    logic       ov;
    logic [3:0] rd;
    int         addr;
    int         steps;
    logic       done;
    foreach (r[i]) r[i] = '0;
    {n, z, c, v} = 4'b0000;
    pc    = '0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 4 * `CODE_WORDS) begin
      inst  = code[(pc >> 2) % `CODE_WORDS];
      rd    = inst[15:12];
      steps++;
      if (!cond_holds(inst[31:28], n, z, c, v)) begin
        pc = pc + 4;
      end else if (inst[27:26] == 2'b10) begin
        // branch to itself ends the program
        done = (inst[23:0] == 24'hfffffe);
        pc   = pc + 8 + {{6{inst[23]}}, inst[23:0], 2'b00};
      end else if (inst[27:26] == 2'b01) begin
        sum  = r[inst[19:16]] + {20'h0, inst[11:0]};
        addr = (sum >> 2) % `DATA_WORDS;
        if (inst[20]) begin
          r[rd] = dmem[addr];
          exp_ret.push_back('{1'b1, rd, r[rd]});
        end else begin
          dmem[addr] = r[rd];
          exp_st.push_back('{1'b1, word_t'(addr), r[rd]});
        end
        pc = pc + 4;
      end else begin
        a  = r[inst[19:16]];
        b  = inst[25] ? {24'h0, inst[7:0]} : r[inst[3:0]];
        cy = c;
        ov = v;
        case (opcode_e'(inst[24:21]))
          OP_AND, OP_TST: res = a & b;
          OP_EOR, OP_TEQ: res = a ^ b;
          OP_SUB, OP_CMP: begin
            {cy, res} = {1'b0, a} + {1'b0, ~b} + 33'd1;
            ov = (a[31] != b[31]) && (res[31] != a[31]);
          end
          OP_RSB: begin
            {cy, res} = {1'b0, b} + {1'b0, ~a} + 33'd1;
            ov = (b[31] != a[31]) && (res[31] != b[31]);
          end
          OP_ADD, OP_CMN: begin
            {cy, res} = {1'b0, a} + {1'b0, b};
            ov = (a[31] == b[31]) && (res[31] != a[31]);
          end
          OP_ORR:  res = a | b;
          OP_BIC:  res = a & ~b;
          OP_MVN:  res = ~b;
          default: res = b;
        endcase
        if (inst[20]) begin
          {n, z, c, v} = {res[31], res == '0, cy, ov};
        end
        // compares only touch the flags
        if (!(inst[24:21] inside {4'h8, 4'h9, 4'ha, 4'hb})) begin
          r[rd] = res;
          exp_ret.push_back('{1'b1, rd, res});
        end
        pc = pc + 4;
      end
    end
  endtask

  ////////////////////////////////////////
  // stimulus and checking

  task automatic load_program();
    for (int i = 0; i < `CODE_WORDS; i++) begin
      @(posedge clk);
      #2;
      prog.we   = 1'b1;
      prog.addr = caddr_t'(i);
      prog.data = code[i];
    end
    @(posedge clk);
    #2;
    prog = '0;
  endtask

  always @(negedge clk) begin : check_outputs
    retire_t want_r;
    store_t  want_s;
    if (nreset && retire.valid) begin
      if (exp_ret.size() == 0) begin
        errors++;
        $display("Unexpected retire to r%0d after the last expected write", retire.rd);
      end else begin
        want_r = exp_ret.pop_front();
        assert (retire.rd == want_r.rd) else begin
          errors++;
          $display("Mismatch retire.rd: got %h, expected %h", retire.rd, want_r.rd);
        end
        assert (retire.data == want_r.data) else begin
          errors++;
          $display("Mismatch retire.data: got %h, expected %h", retire.data, want_r.data);
        end
      end
    end
    if (nreset && store.valid) begin
      if (exp_st.size() == 0) begin
        errors++;
        $display("Unexpected store to word %0d", store.addr);
      end else begin
        want_s = exp_st.pop_front();
        assert (store.addr == want_s.addr && store.data == want_s.data) else begin
          errors++;
          $display("Mismatch store.addr/store.data: got %h/%h, expected %h/%h",
                   store.addr, store.data, want_s.addr, want_s.data);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the program finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    clk    = 1'b0;
    nreset = 1'b0;
    prog   = '0;
    void'($urandom(32'h4777));
    build_program();
    model_program();
    // core stays in reset while code memory fills
    load_program();
    repeat (8) @(posedge clk);
    #2;
    nreset = 1'b1;
    while (exp_ret.size() != 0 || exp_st.size() != 0) begin
      @(posedge clk);
    end
    // core now spins on the final branch
    repeat (4 * `CODE_WORDS) @(posedge clk);
    $display("Checks failed: %0d, assertions failed: %0d", errors, dut0.asrt0.fails);
    if (errors == 0 && dut0.asrt0.fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top import isa_pkg::*; import pipe_pkg::*; (
  input  logic     clk,
  input  logic     nreset,
  input  prog_wr_t prog,
  output retire_t  retire,
  output store_t   store
);

  fd_t      fd;
  de_t      de;
  em_t      em;
  retire_t  mem_fwd;
  logic     stall;
  logic     branch_taken;
  word_t    branch_target;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rd1;
  word_t    rd2;
  word_t    pc_read;
  reg_idx_t ex_load_rd;
  logic     ex_load;

  // r15 as seen by the instruction in decode
  assign pc_read = fd.pc + `PC_READ_OFFSET;

  fetch_stage fetch0 (
    .clk, .nreset, .prog, .stall, .branch_taken, .branch_target, .fd
  );

  decode_stage decode0 (
    .clk, .nreset, .fd, .branch_taken, .rs1, .rs2, .rd1, .rd2,
    .ex_load_rd, .ex_load, .mem_fwd, .wb(retire), .stall, .de
  );

  execute_stage execute0 (
    .clk, .nreset, .de, .ex_load_rd, .ex_load, .branch_taken,
    .branch_target, .em
  );

  memory_stage memory0 (
    .clk, .nreset, .em, .mem_fwd, .store, .wb(retire)
  );

  reg_file rf0 (
    .clk, .nreset, .rs1, .rs2, .pc_read, .rd1, .rd2, .wb(retire)
  );

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import isa_pkg::*; import pipe_pkg::*; (
  input  logic     clk,
  input  logic     nreset,
  input  fd_t      fd,
  input  logic     branch_taken,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input  word_t    rd1,
  input  word_t    rd2,
  input  reg_idx_t ex_load_rd,
  input  logic     ex_load,
  input  retire_t  mem_fwd,
  input  retire_t  wb,
  output logic     stall,
  output de_t      de
);

  cls_e     cls;
  opcode_e  op;
  logic     is_dp;
  logic     is_mem;
  logic     use1;
  logic     use2;
  logic     we_req;
  reg_idx_t rd;
  word_t    op1_val;
  word_t    op2_val;
  de_t      de_q;
  reg_idx_t rs1_q;
  reg_idx_t rs2_q;
  logic     use1_q;
  logic     use2_q;

  // newest producer wins
  function automatic word_t fwd_sel(input reg_idx_t idx, input word_t rf_val,
                                    input retire_t m, input retire_t w);
    if (m.valid && m.rd == idx) begin
      return m.data;
    end
    if (w.valid && w.rd == idx) begin
      return w.data;
    end
    return rf_val;
  endfunction

  assign cls    = cls_e'(fd.inst.dp.cls);
  assign op     = fd.inst.dp.opcode;
  assign is_dp  = (cls == CLS_DP);
  assign is_mem = (cls == CLS_MEM);

  ////////////////////////////////////////
  // field decode

  always_comb begin
    // rn and rd sit at the same bits in both formats
    rs1 = fd.inst.dp.rn;
    // store data comes from rd and register operand2 from rm
    rs2 = is_mem ? fd.inst.mem.rd : fd.inst.dp.op2[3:0];
    rd  = fd.inst.dp.rd;

    use1 = is_mem || (is_dp && !(op inside {OP_MOV, OP_MVN}));
    use2 = (is_dp && !fd.inst.dp.imm) || (is_mem && !fd.inst.mem.l);

    // compares only set flags and r15 is never written
    we_req = (rd != 4'd15) &&
             ((is_dp && !(op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN})) ||
              (is_mem && fd.inst.mem.l));
  end

  ////////////////////////////////////////
  // operands with forwarding

  always_comb begin
    op1_val = fwd_sel(rs1, rd1, mem_fwd, wb);
    if (is_dp && fd.inst.dp.imm) begin
      op2_val = {24'h0, fd.inst.dp.op2[7:0]};
    end else begin
      op2_val = fwd_sel(rs2, rd2, mem_fwd, wb);
    end
  end

  // load result is not ready until the load reaches memory
  assign stall = fd.valid && ex_load &&
                 ((use1 && ex_load_rd == rs1) || (use2 && ex_load_rd == rs2));

  ////////////////////////////////////////
  // decode to execute register

  always_ff @(posedge clk) begin
    if (!nreset) begin
      de_q.valid <= 1'b0;
    end else begin
      de_q.valid <= fd.valid && !stall && !branch_taken;
    end

    de_q.pc   <= fd.pc;
    de_q.inst <= fd.inst;
    de_q.op1  <= op1_val;
    de_q.op2  <= op2_val;
    de_q.rd   <= rd;
    de_q.we   <= we_req;
    rs1_q     <= rs1;
    rs2_q     <= rs2;
    use1_q    <= use1;
    use2_q    <= use2;
  end

  ////////////////////////////////////////
  // forwarding from the instruction just ahead

  // its result reaches the memory stage while this one executes
  always_comb begin
    de = de_q;
    if (use1_q && mem_fwd.valid && mem_fwd.rd == rs1_q) begin
      de.op1 = mem_fwd.data;
    end
    if (use2_q && mem_fwd.valid && mem_fwd.rd == rs2_q) begin
      de.op2 = mem_fwd.data;
    end
  end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_stage import isa_pkg::*; import pipe_pkg::*; (
  input  logic     clk,
  input  logic     nreset,
  input  de_t      de,
  output reg_idx_t ex_load_rd,
  output logic     ex_load,
  output logic     branch_taken,
  output word_t    branch_target,
  output em_t      em
);

  flags_t flags;
  flags_t flags_nxt;
  cls_e   cls;
  logic   is_dp;
  logic   is_mem;
  logic   is_br;
  logic   cond_pass;
  logic   set_flags;
  logic   alu_c;
  logic   alu_v;
  word_t  alu_res;
  word_t  mem_sum;

  function automatic logic cond_ok(input cond_e cond, input flags_t f);
    case (cond)
      COND_EQ: return f.z;
      COND_NE: return !f.z;
      COND_CS: return f.c;
      COND_CC: return !f.c;
      COND_MI: return f.n;
      COND_PL: return !f.n;
      COND_VS: return f.v;
      COND_VC: return !f.v;
      COND_HI: return f.c && !f.z;
      COND_LS: return !f.c || f.z;
      COND_GE: return f.n == f.v;
      COND_LT: return f.n != f.v;
      COND_GT: return !f.z && (f.n == f.v);
      COND_LE: return f.z || (f.n != f.v);
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // returns {carry, overflow, result}, carry is not-borrow on subtract
  function automatic logic [33:0] addsub(input word_t x, input word_t y, input logic sub);
    word_t       y_eff;
    logic [32:0] sum;
    logic        ovf;
    y_eff = sub ? ~y : y;
    sum   = {1'b0, x} + {1'b0, y_eff} + {32'h0, sub};
    ovf   = (x[31] == y_eff[31]) && (sum[31] != x[31]);
    return {sum[32], ovf, sum[31:0]};
  endfunction

  assign cls       = cls_e'(de.inst.dp.cls);
  assign is_dp     = (cls == CLS_DP);
  assign is_mem    = (cls == CLS_MEM);
  assign is_br     = (cls == CLS_BR);
  assign cond_pass = cond_ok(de.inst.dp.cond, flags);

  ////////////////////////////////////////
  // alu

  always_comb begin
    alu_c   = flags.c;
    alu_v   = flags.v;
    alu_res = de.op2;
    case (de.inst.dp.opcode)
      OP_AND, OP_TST: alu_res = de.op1 & de.op2;
      OP_EOR, OP_TEQ: alu_res = de.op1 ^ de.op2;
      OP_SUB, OP_CMP: {alu_c, alu_v, alu_res} = addsub(de.op1, de.op2, 1'b1);
      OP_RSB:         {alu_c, alu_v, alu_res} = addsub(de.op2, de.op1, 1'b1);
      OP_ADD, OP_CMN: {alu_c, alu_v, alu_res} = addsub(de.op1, de.op2, 1'b0);
      OP_ORR:         alu_res = de.op1 | de.op2;
      OP_MOV:         alu_res = de.op2;
      OP_BIC:         alu_res = de.op1 & ~de.op2;
      OP_MVN:         alu_res = ~de.op2;
      default:        alu_res = de.op2;
    endcase

    flags_nxt.n = alu_res[31];
    flags_nxt.z = (alu_res == '0);
    flags_nxt.c = alu_c;
    flags_nxt.v = alu_v;
  end

  assign set_flags = de.valid && cond_pass && is_dp && de.inst.dp.s;

  always_ff @(posedge clk) begin
    if (!nreset) begin
      flags <= '0;
    end else if (set_flags) begin
      flags <= flags_nxt;
    end
  end

  ////////////////////////////////////////
  // branch and address

  assign branch_taken  = de.valid && is_br && cond_pass;
  assign branch_target = de.pc + `PC_READ_OFFSET +
                         {{6{de.inst.br.imm24[23]}}, de.inst.br.imm24, 2'b00};

  assign mem_sum = de.op1 + {20'h0, de.inst.mem.imm12};

  // load in execute, seen by the interlock in decode
  assign ex_load    = de.valid && is_mem && de.inst.mem.l;
  assign ex_load_rd = de.rd;

  ////////////////////////////////////////
  // execute to memory register

  always_ff @(posedge clk) begin
    if (!nreset) begin
      em.valid <= 1'b0;
    end else begin
      em.valid <= de.valid;
    end

    // failed condition travels on as a no-op
    em.rf_we  <= de.we && cond_pass;
    em.rd     <= de.rd;
    em.result <= alu_res;
    em.mem_we <= is_mem && !de.inst.mem.l && cond_pass;
    em.mem_re <= is_mem && de.inst.mem.l && cond_pass;
    em.addr   <= mem_sum[$clog2(`PC_STEP) +: $bits(daddr_t)];
    em.wdata  <= de.op2;
  end

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_stage import isa_pkg::*; import pipe_pkg::*; (
  input  logic     clk,
  input  logic     nreset,
  input  prog_wr_t prog,
  input  logic     stall,
  input  logic     branch_taken,
  input  word_t    branch_target,
  output fd_t      fd
);

  localparam int BYTE_BITS = $clog2(`PC_STEP);

  word_t  code_mem [`CODE_WORDS];
  word_t  pc;
  caddr_t code_addr;

  // address wraps around the code memory
  assign code_addr = pc[BYTE_BITS +: $bits(caddr_t)];

  ////////////////////////////////////////
  // program load port

  always_ff @(posedge clk) begin
    if (prog.we) begin
      code_mem[prog.addr] <= prog.data;
    end
  end

  ////////////////////////////////////////
  // program counter

  always_ff @(posedge clk) begin
    if (!nreset) begin
      pc <= '0;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + `PC_STEP;
    end
  end

  ////////////////////////////////////////
  // fetch to decode register

  always_ff @(posedge clk) begin
    if (!nreset) begin
      fd.valid <= 1'b0;
    end else if (branch_taken) begin
      // younger instruction is on the wrong path
      fd.valid <= 1'b0;
    end else if (!stall) begin
      fd.valid <= 1'b1;
    end

    if (!stall) begin
      fd.pc   <= pc;
      fd.inst <= code_mem[code_addr];
    end
  end

endmodule

/* verilog/isa_pkg.sv */
package isa_pkg;

  typedef logic [3:0]  reg_idx_t;
  typedef logic [31:0] word_t;

  typedef enum logic [3:0] {
    COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3,
    COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7,
    COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'ha, COND_LT = 4'hb,
    COND_GT = 4'hc, COND_LE = 4'hd, COND_AL = 4'he, COND_NV = 4'hf
  } cond_e;

  // adc, sbc and rsc encodings are not implemented
  typedef enum logic [3:0] {
    OP_AND = 4'h0, OP_EOR = 4'h1, OP_SUB = 4'h2, OP_RSB = 4'h3,
    OP_ADD = 4'h4, OP_TST = 4'h8, OP_TEQ = 4'h9, OP_CMP = 4'ha,
    OP_CMN = 4'hb, OP_ORR = 4'hc, OP_MOV = 4'hd, OP_BIC = 4'he,
    OP_MVN = 4'hf
  } opcode_e;

  // instruction class in bits 27:26
  typedef enum logic [1:0] {
    CLS_DP  = 2'b00,
    CLS_MEM = 2'b01,
    CLS_BR  = 2'b10
  } cls_e;

  typedef struct packed {
    cond_e       cond;
    logic [1:0]  cls;
    logic        imm;
    opcode_e     opcode;
    logic        s;
    reg_idx_t    rn;
    reg_idx_t    rd;
    logic [11:0] op2;
  } dp_fmt_t;

  typedef struct packed {
    cond_e       cond;
    logic [1:0]  cls;
    logic        i;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    reg_idx_t    rn;
    reg_idx_t    rd;
    logic [11:0] imm12;
  } mem_fmt_t;

  typedef struct packed {
    cond_e       cond;
    logic [2:0]  cls;
    logic        link;
    logic [23:0] imm24;
  } br_fmt_t;

  typedef union packed {
    dp_fmt_t  dp;
    mem_fmt_t mem;
    br_fmt_t  br;
  } inst_u;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

endpackage

/* verilog/memory_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memory_stage import isa_pkg::*; import pipe_pkg::*; (
  input  logic    clk,
  input  logic    nreset,
  input  em_t     em,
  output retire_t mem_fwd,
  output store_t  store,
  output retire_t wb
);

  word_t data_mem [`DATA_WORDS];
  word_t load_data;

  assign load_data = data_mem[em.addr];

  always_ff @(posedge clk) begin
    if (em.valid && em.mem_we) begin
      data_mem[em.addr] <= em.wdata;
    end
  end

  // loads forward their data once they reach this stage
  assign mem_fwd.valid = em.valid && em.rf_we;
  assign mem_fwd.rd    = em.rd;
  assign mem_fwd.data  = em.mem_re ? load_data : em.result;

  assign store.valid = em.valid && em.mem_we;
  assign store.addr  = word_t'(em.addr);
  assign store.data  = em.wdata;

  ////////////////////////////////////////
  // memory to write-back register

  always_ff @(posedge clk) begin
    wb.rd   <= mem_fwd.rd;
    wb.data <= mem_fwd.data;
    if (!nreset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= mem_fwd.valid;
    end
  end

endmodule

/* verilog/pipe_pkg.sv */
`include "cpu_defs.svh"

package pipe_pkg;
  import isa_pkg::*;

  typedef logic [$clog2(`CODE_WORDS)-1:0] caddr_t;
  typedef logic [$clog2(`DATA_WORDS)-1:0] daddr_t;

  ////////////////////////////////////////
  // external ports

  typedef struct packed {
    logic   we;
    caddr_t addr;
    word_t  data;
  } prog_wr_t;

  // register write, also used for forwarding
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

  // addr is the data memory word index
  typedef struct packed {
    logic  valid;
    word_t addr;
    word_t data;
  } store_t;

  ////////////////////////////////////////
  // stage registers

  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_u inst;
  } fd_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    inst_u    inst;
    word_t    op1;
    word_t    op2;
    reg_idx_t rd;
    logic     we;
  } de_t;

  typedef struct packed {
    logic     valid;
    logic     rf_we;
    reg_idx_t rd;
    word_t    result;
    logic     mem_we;
    logic     mem_re;
    daddr_t   addr;
    word_t    wdata;
  } em_t;

endpackage

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file import isa_pkg::*; import pipe_pkg::*; (
  input  logic     clk,
  input  logic     nreset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  word_t    pc_read,
  output word_t    rd1,
  output word_t    rd2,
  input  retire_t  wb
);

  localparam reg_idx_t PC_IDX = reg_idx_t'(`NUM_REGS);

  word_t regs [`NUM_REGS];

  // r15 is not stored here
  assign rd1 = (rs1 == PC_IDX) ? pc_read : regs[rs1];
  assign rd2 = (rs2 == PC_IDX) ? pc_read : regs[rs2];

  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != PC_IDX) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule
